//--- verilog/bs_pkg.sv
package bs_pkg;

  // ******************************
  // Field widths
  // ******************************
  localparam int BANK_W = 2;   // Up to four bank groups
  localparam int ROW_W  = 14;  // Row address bits
  localparam int COL_W  = 10;  // Column address bits

  // FIFO / bank group index
  typedef logic [BANK_W-1:0] bank_idx_t;

  // Row and column address
  typedef logic [ROW_W-1:0] row_addr_t;
  typedef logic [COL_W-1:0] col_addr_t;

  // ******************************
  // Request and command payload
  // ******************************
  // Same layout for the incoming request and the issued write command
  typedef struct packed {
    bank_idx_t bank;  // Bank group, selects the FIFO
    row_addr_t row;   // Row address
    col_addr_t col;   // Column address
  } bs_req_t;         // 26 bits in total

  // ******************************
  // Issue controller states
  // ******************************
  // IDLE   waits for any non-empty FIFO
  // PICK   start pulse, index counter steps
  // ISSUE  pop selected FIFO, capture head
  // GAP    fixed spacing after each command
  typedef enum logic [1:0] {
    IDLE  = 2'b00,
    PICK  = 2'b01,
    ISSUE = 2'b10,
    GAP   = 2'b11
  } issue_state_t;

endpackage

//--- verilog/bs_req_fifo.sv
`timescale 1ns/1ps

module bs_req_fifo #(
  parameter int FIFO_DEPTH = 4          // Entries in the buffer
) (
  input  logic             clk,
  input  logic             rst_n,       // Sync reset, active low
  input  logic             push,        // Write strobe
  input  logic             pop,         // Read strobe
  input  bs_pkg::bs_req_t  din,         // Request to store
  output bs_pkg::bs_req_t  head,        // Oldest entry
  output logic             empty,
  output logic             full
);

  import bs_pkg::*;

  // Pointer and count widths
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // ******************************
  // Storage and pointers
  // ******************************
  bs_req_t          mem [FIFO_DEPTH];   // Payload only, no reset
  logic [PTR_W-1:0] wr_ptr;             // Next slot to write
  logic [PTR_W-1:0] rd_ptr;             // Oldest slot
  logic [CNT_W-1:0] count;              // Entries held

  logic do_push;
  logic do_pop;

  // Pop only with data present
  assign do_pop  = pop && !empty;
  // Full FIFO still takes a push when a pop frees a slot this cycle
  assign do_push = push && (!full || do_pop);

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign head  = mem[rd_ptr];           // Always the oldest entry

  // Write port
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // ******************************
  // Pointer and count update
  // ******************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at the last slot
        if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) wr_ptr <= '0;
        else                                  wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) rd_ptr <= '0;
        else                                  rd_ptr <= rd_ptr + 1'b1;
      end
      // Count moves only when exactly one side acts
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Idle or simultaneous push/pop
      endcase
    end
  end

endmodule

//--- verilog/bs_rr_idx.sv
`timescale 1ns/1ps

module bs_rr_idx #(
  parameter int FIFO_NUM = 3            // FIFOs to cycle over, 2 to 4
) (
  input  logic                clk,
  input  logic                rst_n,    // Sync reset, active low
  input  logic                start,    // Step to the next valid FIFO
  input  logic [FIFO_NUM-1:0] valid,    // Non-empty FIFOs
  output bs_pkg::bank_idx_t   idx       // Current FIFO index
);

  import bs_pkg::*;

  bank_idx_t cur_idx;                   // Registered index
  bank_idx_t nxt_idx;                   // Candidate after a step

  assign idx = cur_idx;

  // ******************************
  // Cyclic search
  // ******************************
  // Walks from the farthest distance down to one, so the nearest
  // set bit after the current index is the one that sticks
  function automatic bank_idx_t pick_next(bank_idx_t base, logic [FIFO_NUM-1:0] vld);
    bank_idx_t sel;
    int        cand;
    sel = base;                         // Nothing valid keeps the index
    for (int k = FIFO_NUM; k >= 1; k--) begin
      cand = int'(base) + k;
      if (cand >= FIFO_NUM) cand = cand - FIFO_NUM;  // Modulo FIFO_NUM
      if (vld[cand]) sel = bank_idx_t'(cand);
    end
    return sel;
  endfunction

  always_comb begin
    nxt_idx = cur_idx;
    if (start) nxt_idx = pick_next(cur_idx, valid);
  end

  // Index register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Last index, so FIFO 0 is the first candidate
      cur_idx <= bank_idx_t'(FIFO_NUM - 1);
    end else begin
      cur_idx <= nxt_idx;
    end
  end

endmodule

//--- verilog/bs_issue_ctrl.sv
`timescale 1ns/1ps

module bs_issue_ctrl #(
  parameter int FIFO_NUM   = 3,         // Number of request FIFOs
  parameter int GAP_CYCLES = 2          // Idle cycles after each command
) (
  input  logic                clk,
  input  logic                rst_n,      // Sync reset, active low
  input  logic [FIFO_NUM-1:0] valid,      // Non-empty FIFOs
  input  bs_pkg::bank_idx_t   idx,        // Selected FIFO
  input  bs_pkg::bs_req_t     head,       // Head of selected FIFO
  output logic                start,      // Index counter step
  output logic [FIFO_NUM-1:0] pop,        // One-hot pop in ISSUE
  output logic                cmd_valid,  // One-cycle command strobe
  output bs_pkg::bs_req_t     cmd         // Write command
);

  import bs_pkg::*;

  localparam int GAP_W = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;

  issue_state_t     state;
  issue_state_t     state_nxt;
  logic [GAP_W-1:0] gap_cnt;            // Remaining gap cycles minus one

  // ******************************
  // Next state
  // ******************************
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (|valid) state_nxt = PICK;
      PICK:    state_nxt = ISSUE;       // Index settles on this edge
      ISSUE:   state_nxt = (GAP_CYCLES == 0) ? IDLE : GAP;
      GAP:     if (gap_cnt == '0) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Gap counter, loaded while the command is captured
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gap_cnt <= '0;
    end else if (state == ISSUE) begin
      gap_cnt <= GAP_W'(GAP_CYCLES - 1);
    end else if (state == GAP && gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  // ******************************
  // Outputs
  // ******************************
  assign start = (state == PICK);       // Exactly one cycle per command

  // Decode idx into the pop vector
  always_comb begin
    pop = '0;
    if (state == ISSUE) begin
      for (int i = 0; i < FIFO_NUM; i++) begin
        if (idx == bank_idx_t'(i)) pop[i] = 1'b1;
      end
    end
  end

  // Command strobe, high in the first gap cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= (state == ISSUE);
    end
  end

  // Command payload
  always_ff @(posedge clk) begin
    if (state == ISSUE) cmd <= head;    // Head taken as it is popped
  end

endmodule

//--- verilog/bank_sched_top.sv
`timescale 1ns/1ps

module bank_sched_top #(
  parameter int FIFO_NUM   = 3,         // Bank groups, 2 to 4
  parameter int FIFO_DEPTH = 4,         // Entries per FIFO
  parameter int GAP_CYCLES = 2          // Spacing after each command
) (
  input  logic                clk,
  input  logic                rst_n,      // Sync reset, active low
  input  logic                req_valid,  // Request strobe
  input  bs_pkg::bs_req_t     req,        // Request payload
  output logic                cmd_valid,  // Command strobe
  output bs_pkg::bs_req_t     cmd,        // Issued write command
  output logic [FIFO_NUM-1:0] full        // Per-FIFO full level
);

  import bs_pkg::*;

  logic [FIFO_NUM-1:0] push;            // Decoded push per FIFO
  logic [FIFO_NUM-1:0] pop;             // From the controller
  logic [FIFO_NUM-1:0] empty;
  logic [FIFO_NUM-1:0] valid;           // Non-empty FIFOs
  bs_req_t             heads [FIFO_NUM];
  bs_req_t             head_sel;        // Head of FIFO idx
  bank_idx_t           idx;
  logic                start;

  assign valid = ~empty;

  // ******************************
  // Request FIFOs
  // ******************************
  for (genvar g = 0; g < FIFO_NUM; g++) begin : g_fifo
    // Bank values of FIFO_NUM or more match no FIFO and are dropped
    assign push[g] = req_valid && (req.bank == bank_idx_t'(g));

    bs_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (push[g]),
      .pop   (pop[g]),
      .din   (req),
      .head  (heads[g]),
      .empty (empty[g]),
      .full  (full[g])
    );
  end

  // Head mux
  always_comb begin
    head_sel = heads[0];
    for (int i = 1; i < FIFO_NUM; i++) begin
      if (idx == bank_idx_t'(i)) head_sel = heads[i];
    end
  end

  bs_rr_idx #(.FIFO_NUM(FIFO_NUM)) u_rr_idx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .valid (valid),
    .idx   (idx)
  );

  bs_issue_ctrl #(
    .FIFO_NUM   (FIFO_NUM),
    .GAP_CYCLES (GAP_CYCLES)
  ) u_issue_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .idx       (idx),
    .head      (head_sel),
    .start     (start),
    .pop       (pop),
    .cmd_valid (cmd_valid),
    .cmd       (cmd)
  );

endmodule

//--- dv/bank_sched_assertions.sv
`timescale 1ns/1ps

module bank_sched_assertions #(
  parameter int FIFO_NUM = 3
) (
  input logic                 clk,
  input logic                 rst_n,
  input bs_pkg::issue_state_t state,      // Controller FSM state
  input logic                 start,
  input logic [FIFO_NUM-1:0]  pop,
  input logic [FIFO_NUM-1:0]  valid       // Non-empty FIFOs
);

  import bs_pkg::*;

  int unsigned fail_count = 0;            // Read by the testbench

  // ******************************
  // Controller protocol
  // ******************************
  // Start steps the index only while some FIFO holds a request
  a_start_in_pick: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (state == PICK) && (valid != '0))
    else begin
      $error("start outside PICK or with every FIFO empty");
      fail_count++;
    end

  a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    (state == ISSUE) |-> $onehot(pop))
    else begin
      $error("pop not one-hot in ISSUE");
      fail_count++;
    end

  // Pop lands in ISSUE one cycle after the start pulse
  a_pop_only_issue: assert property (@(posedge clk) disable iff (!rst_n)
    (pop != '0) |-> (state == ISSUE) && $past(start))
    else begin
      $error("pop outside ISSUE or not one cycle after start");
      fail_count++;
    end

  // Never pop a FIFO that holds nothing
  a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    (pop & ~valid) == '0)
    else begin
      $error("pop aimed at an empty FIFO");
      fail_count++;
    end

endmodule

bind bs_issue_ctrl bank_sched_assertions #(.FIFO_NUM(FIFO_NUM)) u_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .state (state),
  .start (start),
  .pop   (pop),
  .valid (valid)
);

//--- dv/bank_sched_tb.sv
`timescale 1ns/1ps

module bank_sched_tb;

  import bs_pkg::*;

  // ******************************
  // Configuration
  // ******************************
  localparam int FIFO_NUM      = 3;
  localparam int FIFO_DEPTH    = 4;
  localparam int GAP_CYCLES    = 2;
  localparam int MIN_SPACING   = GAP_CYCLES + 2;  // PICK, ISSUE, then the gap
  localparam int SEED          = 34716;
  localparam int CMD_TIMEOUT   = 20;              // Cycles for one lone request
  localparam int DRAIN_TIMEOUT = 400;             // Cycles to empty every queue

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  bs_req_t             req;
  logic                cmd_valid;
  bs_req_t             cmd;
  logic [FIFO_NUM-1:0] full;

  // ******************************
  // Reference model state
  // ******************************
  bs_req_t             model_q [FIFO_NUM][$];  // One queue per bank group
  logic [FIFO_NUM-1:0] empty_hist [$];         // Queue emptiness per cycle
  bank_idx_t           model_idx;              // Last bank served
  logic                prev_valid;             // Request seen one cycle ago
  bs_req_t             prev_req;
  logic                monitor_on;
  int                  since_cmd;              // Cycles since last command or -1 before first
  int                  accepted_cnt;
  int                  dropped_cnt;            // Pushes into a full queue
  int                  ignored_cnt;            // Bank out of range
  int                  issued_cnt;
  string               test_name;

  bank_sched_top #(
    .FIFO_NUM   (FIFO_NUM),
    .FIFO_DEPTH (FIFO_DEPTH),
    .GAP_CYCLES (GAP_CYCLES)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .full      (full)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;               // 100 ns period
  end

  // ******************************
  // Failure and compare tasks
  // ******************************
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_cmd(input bs_req_t exp, input bs_req_t act);
    if (act !== exp) begin
      stop_on_error($sformatf({"Error: test %s, cmd expected bank %0d row 0x%h col 0x%h,",
                               " actual bank %0d row 0x%h col 0x%h"}, test_name,
                              exp.bank, exp.row, exp.col, act.bank, act.row, act.col));
    end
  endtask

  task automatic check_full(input logic [FIFO_NUM-1:0] exp, input logic [FIFO_NUM-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: test %s, full expected %b, actual %b",
                              test_name, exp, act));
    end
  endtask

  task automatic check_gap(input int act);
    if (act < MIN_SPACING) begin
      stop_on_error($sformatf("Error: test %s, cmd spacing expected >= %0d, actual %0d",
                              test_name, MIN_SPACING, act));
    end
  endtask

  // ******************************
  // Model helpers
  // ******************************
  // First non-empty bank after base in cyclic order with base itself last
  function automatic bank_idx_t next_rr_bank(input bank_idx_t base,
                                             input logic [FIFO_NUM-1:0] emp);
    int cand;
    cand = int'(base);
    for (int k = 0; k < FIFO_NUM; k++) begin
      cand = (cand + 1) % FIFO_NUM;
      if (!emp[cand]) return bank_idx_t'(cand);
    end
    return base;                          // Nothing pending
  endfunction

  function automatic logic [FIFO_NUM-1:0] model_empty();
    logic [FIFO_NUM-1:0] emp;
    for (int b = 0; b < FIFO_NUM; b++) emp[b] = (model_q[b].size() == 0);
    return emp;
  endfunction

  function automatic logic [FIFO_NUM-1:0] model_full();
    logic [FIFO_NUM-1:0] fl;
    for (int b = 0; b < FIFO_NUM; b++) fl[b] = (model_q[b].size() == FIFO_DEPTH);
    return fl;
  endfunction

  // One model step per cycle at the falling edge where outputs are settled
  task automatic update_model();
    logic [FIFO_NUM-1:0] pick_emp;
    bank_idx_t           exp_bank;
    if (DUT.u_issue_ctrl.u_assert.fail_count != 0) begin
      stop_on_error("A bound assertion on the issue controller failed");
    end
    if (since_cmd >= 0) since_cmd++;
    if (cmd_valid === 1'b1) begin
      pick_emp = empty_hist[empty_hist.size() - 2];   // State in the PICK cycle
      exp_bank = next_rr_bank(model_idx, pick_emp);
      if (model_q[exp_bank].size() == 0) begin
        stop_on_error($sformatf("Command in test %s while bank %0d had nothing pending",
                                test_name, exp_bank));
      end
      check_cmd(model_q[exp_bank][0], cmd);
      void'(model_q[exp_bank].pop_front());
      model_idx = exp_bank;
      if (since_cmd >= 0) check_gap(since_cmd);
      since_cmd = 0;
      issued_cnt++;
    end else if (cmd_valid !== 1'b0) begin
      stop_on_error($sformatf("cmd_valid is unknown in test %s", test_name));
    end
    // Request from last cycle lands after the pop so a full queue can still take it
    if (prev_valid) begin
      if (int'(prev_req.bank) >= FIFO_NUM) ignored_cnt++;
      else if (model_q[prev_req.bank].size() >= FIFO_DEPTH) dropped_cnt++;
      else begin
        model_q[prev_req.bank].push_back(prev_req);
        accepted_cnt++;
      end
    end
    empty_hist.push_back(model_empty());
    if (empty_hist.size() > 8) void'(empty_hist.pop_front());
    check_full(model_full(), full);
    prev_valid = req_valid;
    prev_req   = req;
  endtask

  always @(negedge clk) begin
    if (monitor_on) update_model();
  end

  // ******************************
  // Stimulus
  // ******************************
  task automatic drive_req(input logic vld, input bank_idx_t bank);
    bs_req_t r;
    @(posedge clk);
    r.bank = bank;
    r.row  = row_addr_t'($urandom);
    r.col  = col_addr_t'($urandom);
    req_valid <= vld;
    req       <= r;                       // Payload random even when idle
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_req(1'b0, '0);
  endtask

  task automatic random_traffic(input int n, input int density, input bit with_invalid);
    logic      vld;
    bank_idx_t bank;
    for (int i = 0; i < n; i++) begin
      vld = ($urandom_range(99) < density);
      if (with_invalid) bank = bank_idx_t'($urandom_range(3));
      else              bank = bank_idx_t'($urandom_range(FIFO_NUM - 1));
      drive_req(vld, bank);
    end
  endtask

  // Waits for one command strobe with inputs held quiet
  task automatic wait_for_cmd(input int limit);
    int n;
    n = 0;
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    while (cmd_valid !== 1'b1) begin
      if (n >= limit) begin
        stop_on_error($sformatf("Timeout in test %s: no command within %0d cycles",
                                test_name, limit));
      end
      n++;
      @(negedge clk);
    end
  endtask

  // Stops traffic and waits until the model holds nothing pending
  task automatic drain_queues(input int limit);
    int n;
    n = 0;
    @(posedge clk);
    req_valid <= 1'b0;
    @(posedge clk);
    while (model_empty() != '1 || prev_valid) begin
      if (n >= limit) begin
        stop_on_error($sformatf("Timeout in test %s: requests still pending after %0d cycles",
                                test_name, limit));
      end
      n++;
      @(posedge clk);
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************
  initial begin
    bank_idx_t busy;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    monitor_on   = 1'b0;
    model_idx    = bank_idx_t'(FIFO_NUM - 1);  // Bank 0 is the first candidate
    prev_valid   = 1'b0;
    prev_req     = '0;
    since_cmd    = -1;
    accepted_cnt = 0;
    dropped_cnt  = 0;
    ignored_cnt  = 0;
    issued_cnt   = 0;
    empty_hist.push_back('1);
    empty_hist.push_back('1);
    void'($urandom(SEED));
    test_name = "reset";

    repeat (16) @(posedge clk);
    rst_n      <= 1'b1;
    monitor_on <= 1'b1;

    test_name = "idle_after_reset";       // No strobe and full stays zero
    idle_cycles(10);

    // Bank 0 wins over the earlier request to the last bank
    test_name = "first_pick";
    drive_req(1'b1, bank_idx_t'(FIFO_NUM - 1));
    drive_req(1'b1, bank_idx_t'(0));
    wait_for_cmd(CMD_TIMEOUT);
    wait_for_cmd(CMD_TIMEOUT);
    idle_cycles(MIN_SPACING);

    test_name = "random_density";
    for (int blk = 0; blk < 10; blk++) random_traffic(30, $urandom_range(10, 90), 1'b0);

    test_name = "burst_one_bank";         // Fills one FIFO and overruns it
    for (int k = 0; k < 3; k++) begin
      busy = bank_idx_t'($urandom_range(FIFO_NUM - 1));
      random_traffic(1, 0, 1'b0);
      repeat (25) drive_req(1'b1, busy);
      idle_cycles($urandom_range(2, 12));
    end

    test_name = "invalid_banks";
    if (FIFO_NUM < 4) begin
      for (int i = 0; i < 40; i++) begin
        if ($urandom_range(1) == 0) begin
          drive_req(1'b1, bank_idx_t'(FIFO_NUM + $urandom_range(3 - FIFO_NUM)));
        end else begin
          drive_req(1'b1, bank_idx_t'($urandom_range(FIFO_NUM - 1)));
        end
      end
    end

    test_name = "random_mixed";
    for (int blk = 0; blk < 8; blk++) random_traffic(25, $urandom_range(5, 100), 1'b1);

    test_name = "drain";
    drain_queues(DRAIN_TIMEOUT);
    idle_cycles(2 * MIN_SPACING);         // No stray strobe once idle

    if (issued_cnt == accepted_cnt && model_empty() == '1 &&
        DUT.u_issue_ctrl.u_assert.fail_count == 0) begin
      $display("Accepted %0d, dropped %0d, ignored %0d, issued %0d",
               accepted_cnt, dropped_cnt, ignored_cnt, issued_cnt);
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("Error: test %s, issued commands expected %0d, actual %0d",
                              test_name, accepted_cnt, issued_cnt));
    end
  end

endmodule

//--- sources.f
verilog/bs_pkg.sv
verilog/bs_req_fifo.sv
verilog/bs_rr_idx.sv
verilog/bs_issue_ctrl.sv
verilog/bank_sched_top.sv
dv/bank_sched_assertions.sv
dv/bank_sched_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the bank scheduler testbench with Verilator and runs it.
# Exit status is 0 only when the log holds no failure report.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=bank_sched_sim
LOG=sim.log

# Compile and elaborate
verilator --binary --timing --assert -Wno-fatal \
  --top-module bank_sched_tb \
  -f sources.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Run, keeping going past the first assertion error so the testbench reports it
"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

# Failure text in the log decides the outcome
if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
